// File: src.f
+incdir+src
src/i2c_codec_pkg.sv
src/i2c_bit_engine.sv
src/i2c_frame_sequencer.sv
src/wm8960_ctrl_top.sv
tb/codec_i2c_model.sv
tb/wm8960_ctrl_props.sv
tb/wm8960_ctrl_tb.sv

// File: Bender.yml
package:
  name: wm8960_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/i2c_codec_pkg.sv
      - src/i2c_bit_engine.sv
      - src/i2c_frame_sequencer.sv
      - src/wm8960_ctrl_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/codec_i2c_model.sv
      - tb/wm8960_ctrl_props.sv
      - tb/wm8960_ctrl_tb.sv

// File: tb/wm8960_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "i2c_codec_defs.svh"

module wm8960_ctrl_tb;

  localparam logic [6:0] codec_addr = 7'h1a;
  localparam int         max_wait   = 5000;

  logic       clk;
  logic       rst;
  logic       enable;
  logic [6:0] din_device_address;
  logic       din_rd_wr;
  logic [6:0] din_register_address;
  logic [8:0] din_register_data;
  logic       din_valid;
  logic       din_ready;
  logic       i2c_sclk;
  logic [8:0] dout_register_data;
  logic [2:0] dout_acks_received;
  logic       dout_valid;
  logic       dout_ready;
  wire        i2c_sda;

  int         errors;
  int         seed;
  logic [8:0] exp_mem [0:127];
  logic [6:0] written_q [$];

  pullup (i2c_sda);

  wm8960_ctrl_top uut (
    .clk                  (clk),
    .rst                  (rst),
    .enable               (enable),
    .din_device_address   (din_device_address),
    .din_rd_wr            (din_rd_wr),
    .din_register_address (din_register_address),
    .din_register_data    (din_register_data),
    .din_valid            (din_valid),
    .din_ready            (din_ready),
    .i2c_sda              (i2c_sda),
    .i2c_sclk             (i2c_sclk),
    .dout_register_data   (dout_register_data),
    .dout_acks_received   (dout_acks_received),
    .dout_valid           (dout_valid),
    .dout_ready           (dout_ready)
  );

  codec_i2c_model #(.dev_addr(codec_addr)) codec (
    .scl (i2c_sclk),
    .sda (i2c_sda)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("ERROR: %s", what);
  endtask

  task automatic wait_din_ready(input int limit);
    int n;
    n = 0;
    while (!din_ready && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!din_ready) report_problem("din_ready did not rise in time");
  endtask

  task automatic send_request(input logic [6:0] dev, input logic rw,
                              input logic [6:0] ra, input logic [8:0] wd);
    int n;
    @(posedge clk);
    din_device_address   <= dev;
    din_rd_wr            <= rw;
    din_register_address <= ra;
    din_register_data    <= wd;
    din_valid            <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!din_ready && n < max_wait);
    din_valid <= 1'b0;
    if (!din_ready) report_problem("request was never accepted");
  endtask

  task automatic get_response(output logic [8:0] rdata, output logic [2:0] acks);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!dout_valid && n < max_wait);
    if (!dout_valid) report_problem("no response before timeout");
    rdata = dout_register_data;
    acks  = dout_acks_received;
  endtask

  task automatic reset_sequence();
    repeat (2) @(posedge clk);
    check_value("dout_valid", dout_valid, 0);
    check_value("i2c_sclk", i2c_sclk, 1);
    check_value("din_ready", din_ready, 0);
    rst <= 1'b0;
    @(posedge clk);
    check_value("dout_valid", dout_valid, 0);
    check_value("i2c_sclk", i2c_sclk, 1);
    wait_din_ready(2);
  endtask

  task automatic write_random_register();
    logic [6:0] ra;
    logic [8:0] wd;
    logic [8:0] rdata;
    logic [2:0] acks;
    ra = 7'($random(seed));
    wd = 9'($random(seed));
    send_request(codec_addr, 1'b0, ra, wd);
    get_response(rdata, acks);
    check_value("dout_acks_received", acks, 3'b111);
    check_value("dout_register_data", rdata, 9'h000);
    check_value("codec.mem", codec.mem[ra], wd);
    exp_mem[ra] = wd;
    written_q.push_back(ra);
  endtask

  task automatic readback_register(input logic [6:0] ra);
    logic [8:0] rdata;
    logic [2:0] acks;
    send_request(codec_addr, 1'b1, ra, 9'h000);
    get_response(rdata, acks);
    check_value("dout_acks_received", acks, 3'b111);
    check_value("dout_register_data", rdata, exp_mem[ra]);
  endtask

  task automatic access_other_device();
    logic [8:0] rdata;
    logic [2:0] acks;
    send_request(codec_addr ^ 7'h05, 1'b0, 7'h10, 9'h0f0);
    get_response(rdata, acks);
    check_value("dout_acks_received", acks, 3'b000);
    send_request(codec_addr ^ 7'h05, 1'b1, 7'h10, 9'h000);
    get_response(rdata, acks);
    check_value("dout_acks_received", acks, 3'b000);
    check_value("dout_register_data", rdata, 9'h1ff);
  endtask

  task automatic stall_response(input logic [6:0] ra);
    logic [8:0] rdata;
    logic [2:0] acks;
    int         hold;
    hold = 1 + ($unsigned($random(seed)) % 20);
    dout_ready <= 1'b0;
    send_request(codec_addr, 1'b1, ra, 9'h000);
    get_response(rdata, acks);
    check_value("dout_register_data", rdata, exp_mem[ra]);
    check_value("dout_acks_received", acks, 3'b111);
    repeat (hold) begin
      @(posedge clk);
      check_value("dout_valid", dout_valid, 1);
      check_value("dout_register_data", dout_register_data, rdata);
      check_value("dout_acks_received", dout_acks_received, acks);
      check_value("din_ready", din_ready, 0);
    end
    dout_ready <= 1'b1;
    @(posedge clk);
    check_value("dout_valid", dout_valid, 1);
    @(posedge clk);
    check_value("dout_valid", dout_valid, 0);
  endtask

  task automatic abort_with_enable();
    send_request(codec_addr, 1'b0, 7'h7f, 9'h155);
    repeat (200) @(posedge clk);
    enable <= 1'b0;
    repeat (2) @(posedge clk);
    check_value("i2c_sclk", i2c_sclk, 1);
    check_value("dout_valid", dout_valid, 0);
    enable <= 1'b1;
    @(posedge clk);
    wait_din_ready(2);
    write_random_register();
    readback_register(written_q[$]);
  endtask

  initial begin
    rst                  = 1'b1;
    enable               = 1'b1;
    din_device_address   = '0;
    din_rd_wr            = 1'b0;
    din_register_address = '0;
    din_register_data    = '0;
    din_valid            = 1'b0;
    dout_ready           = 1'b1;
    errors               = 0;
    seed                 = 16;

    reset_sequence();
    repeat (3) write_random_register();
    foreach (written_q[i]) readback_register(written_q[i]);
    access_other_device();
    stall_response(written_q[0]);
    abort_with_enable();

    $display("errors: %0d  assertion failures: %0d", errors, uut.u_props.fail_count);
    if (errors == 0 && uut.u_props.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/wm8960_ctrl_props.sv
`timescale 1ns/100ps
`default_nettype none

module wm8960_ctrl_props (
  input logic clk,
  input logic rst,
  input logic enable,
  input logic din_ready,
  input logic dout_valid,
  input logic dout_ready,
  input logic i2c_sclk
);

  int fail_count = 0;

  no_overlap: assert property (@(posedge clk) disable iff (rst || !enable)
    !(din_ready && dout_valid))
    else begin
      fail_count++;
      $error("din_ready and dout_valid high together");
    end

  // response stays up until taken
  valid_hold: assert property (@(posedge clk) disable iff (rst || !enable)
    dout_valid && !dout_ready |=> dout_valid)
    else begin
      fail_count++;
      $error("dout_valid dropped before dout_ready");
    end

  idle_scl: assert property (@(posedge clk) disable iff (rst || !enable)
    din_ready |-> i2c_sclk)
    else begin
      fail_count++;
      $error("SCL low while ready for a request");
    end

endmodule

bind wm8960_ctrl_top wm8960_ctrl_props u_props (
  .clk        (clk),
  .rst        (rst),
  .enable     (enable),
  .din_ready  (din_ready),
  .dout_valid (dout_valid),
  .dout_ready (dout_ready),
  .i2c_sclk   (i2c_sclk)
);

`default_nettype wire

// File: tb/codec_i2c_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "i2c_codec_defs.svh"

module codec_i2c_model #(
  parameter logic [`CODEC_DEV_ADDR_W-1:0] dev_addr = 7'h1a
) (
  input  wire logic scl,
  inout  wire logic sda
);

  logic [`CODEC_REG_DATA_W-1:0] mem [0:(1<<`CODEC_REG_ADDR_W)-1];
  logic                         active;
  logic                         drive_low;
  logic                         match;
  logic                         rd;
  logic [`CODEC_DEV_ADDR_W-1:0] dev_sh;
  logic [`CODEC_REG_ADDR_W-1:0] reg_sh;
  logic [`CODEC_REG_DATA_W-1:0] data_sh;
  int                           idx;

  // open drain, only ever pulls low
  assign sda = drive_low ? 1'b0 : 1'bz;

  initial begin
    active    = 1'b0;
    drive_low = 1'b0;
    match     = 1'b0;
    rd        = 1'b0;
    idx       = 0;
    for (int i = 0; i < (1 << `CODEC_REG_ADDR_W); i++) begin
      mem[i] = 9'(i * 5) ^ 9'h0a5;
    end
  end

  // start and stop seen while SCL is high
  always @(negedge sda) begin
    if (scl === 1'b1) begin
      active    = 1'b1;
      match     = 1'b0;
      drive_low = 1'b0;
      idx       = -1;
    end
  end

  always @(posedge sda) begin
    if (scl === 1'b1) begin
      active    = 1'b0;
      drive_low = 1'b0;
    end
  end

  // slots 0..7 byte one, 8 ack, 9..16 byte two, 17 ack, 18..25 byte three, 26 ack
  always @(posedge scl) begin
    if (active) begin
      if (idx >= 0 && idx <= 6) begin
        dev_sh = {dev_sh[`CODEC_DEV_ADDR_W-2:0], sda};
      end else if (idx == 7) begin
        rd    = sda;
        match = (dev_sh == dev_addr);
      end else if (idx >= 9 && idx <= 15) begin
        reg_sh = {reg_sh[`CODEC_REG_ADDR_W-2:0], sda};
      end else if (idx == 16 || (idx >= 18 && idx <= 25)) begin
        data_sh = {data_sh[`CODEC_REG_DATA_W-2:0], sda};
        if (idx == 25 && match && !rd) begin
          mem[reg_sh] = data_sh;
        end
      end
    end
  end

  always @(negedge scl) begin
    if (active) begin
      idx       = idx + 1;
      drive_low = 1'b0;
      if (match) begin
        if (idx == 8 || idx == 17 || idx == 26) begin
          drive_low = 1'b1;
        end else if (rd && idx == 16) begin
          drive_low = ~mem[reg_sh][8];
        end else if (rd && idx >= 18 && idx <= 25) begin
          drive_low = ~mem[reg_sh][25 - idx];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/wm8960_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "i2c_codec_defs.svh"

module wm8960_ctrl_top #(
  parameter int clk_div = `CODEC_CLK_DIV
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         enable,
  input  logic [`CODEC_DEV_ADDR_W-1:0] din_device_address,
  input  logic                         din_rd_wr,
  input  logic [`CODEC_REG_ADDR_W-1:0] din_register_address,
  input  logic [`CODEC_REG_DATA_W-1:0] din_register_data,
  input  logic                         din_valid,
  output logic                         din_ready,
  inout  wire logic                    i2c_sda,
  output logic                         i2c_sclk,
  output logic [`CODEC_REG_DATA_W-1:0] dout_register_data,
  output logic [ `CODEC_ACK_SLOTS-1:0] dout_acks_received,
  output logic                         dout_valid,
  input  logic                         dout_ready
);

  logic                   clr;
  i2c_codec_pkg::bus_op_e op;
  logic                   op_valid;
  logic                   tx_bit;
  logic                   op_done;
  logic                   rx_bit;
  logic                   sda_oe;
  logic                   sda_out;
  logic                   sda_in;

  // disable acts as a reset on both blocks
  assign clr = rst | ~enable;

  // open-drain style pin, released when not driving
  assign i2c_sda = sda_oe ? sda_out : 1'bz;
  assign sda_in  = i2c_sda;

  i2c_frame_sequencer u_seq (
    .clk                  (clk),
    .rst                  (clr),
    .din_device_address   (din_device_address),
    .din_rd_wr            (din_rd_wr),
    .din_register_address (din_register_address),
    .din_register_data    (din_register_data),
    .din_valid            (din_valid),
    .din_ready            (din_ready),
    .dout_register_data   (dout_register_data),
    .dout_acks_received   (dout_acks_received),
    .dout_valid           (dout_valid),
    .dout_ready           (dout_ready),
    .op                   (op),
    .op_valid             (op_valid),
    .tx_bit               (tx_bit),
    .op_done              (op_done),
    .rx_bit               (rx_bit)
  );

  i2c_bit_engine #(
    .clk_div (clk_div)
  ) u_eng (
    .clk      (clk),
    .rst      (clr),
    .op       (op),
    .op_valid (op_valid),
    .tx_bit   (tx_bit),
    .sda_in   (sda_in),
    .op_done  (op_done),
    .rx_bit   (rx_bit),
    .scl      (i2c_sclk),
    .sda_oe   (sda_oe),
    .sda_out  (sda_out)
  );

endmodule

`default_nettype wire

// File: src/i2c_frame_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "i2c_codec_defs.svh"

module i2c_frame_sequencer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`CODEC_DEV_ADDR_W-1:0] din_device_address,
  input  logic                         din_rd_wr,
  input  logic [`CODEC_REG_ADDR_W-1:0] din_register_address,
  input  logic [`CODEC_REG_DATA_W-1:0] din_register_data,
  input  logic                         din_valid,
  output logic                         din_ready,
  output logic [`CODEC_REG_DATA_W-1:0] dout_register_data,
  output logic [ `CODEC_ACK_SLOTS-1:0] dout_acks_received,
  output logic                         dout_valid,
  input  logic                         dout_ready,
  output i2c_codec_pkg::bus_op_e       op,
  output logic                         op_valid,
  output logic                         tx_bit,
  input  logic                         op_done,
  input  logic                         rx_bit
);

  localparam int ack_w = $clog2(`CODEC_ACK_SLOTS);

  localparam logic [3:0] dev_last  = 4'(`CODEC_DEV_ADDR_W - 1);
  localparam logic [3:0] reg_last  = 4'(`CODEC_REG_ADDR_W - 1);
  localparam logic [3:0] data_last = 4'(`CODEC_REG_DATA_W - 1);

  i2c_codec_pkg::frame_field_e state;

  logic                         busy;
  logic                         accept;
  logic [3:0]                   bit_cnt;
  logic [ack_w-1:0]             ack_cnt;
  logic [`CODEC_DEV_ADDR_W-1:0] dev_q;
  logic                         rd_wr_q;
  logic [`CODEC_REG_ADDR_W-1:0] reg_q;
  logic [`CODEC_REG_DATA_W-1:0] data_q;

  assign accept = din_valid & din_ready;

  // one bus op per field step, only when the engine is free
  assign op_valid = ~busy & (state != i2c_codec_pkg::ff_idle)
                          & (state != i2c_codec_pkg::ff_output);

  always_comb begin
    op     = i2c_codec_pkg::op_write;
    tx_bit = 1'b1;
    case (state)
      i2c_codec_pkg::ff_start:    op = i2c_codec_pkg::op_start;
      i2c_codec_pkg::ff_dev_addr: tx_bit = dev_q[`CODEC_DEV_ADDR_W-1];
      i2c_codec_pkg::ff_rd_wr:    tx_bit = rd_wr_q;
      i2c_codec_pkg::ff_ack:      op = i2c_codec_pkg::op_read;
      i2c_codec_pkg::ff_reg_addr: tx_bit = reg_q[`CODEC_REG_ADDR_W-1];
      i2c_codec_pkg::ff_data: begin
        if (rd_wr_q) begin
          op = i2c_codec_pkg::op_read;
        end else begin
          tx_bit = data_q[`CODEC_REG_DATA_W-1];
        end
      end
      i2c_codec_pkg::ff_stop:     op = i2c_codec_pkg::op_stop;
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= i2c_codec_pkg::ff_idle;
      busy       <= 1'b0;
      din_ready  <= 1'b0;
      dout_valid <= 1'b0;
      bit_cnt    <= '0;
      ack_cnt    <= '0;
    end else begin
      if (op_valid) begin
        busy <= 1'b1;
      end
      if (op_done) begin
        busy <= 1'b0;
      end

      case (state)
        i2c_codec_pkg::ff_idle: begin
          if (accept) begin
            din_ready <= 1'b0;
            bit_cnt   <= '0;
            ack_cnt   <= '0;
            state     <= i2c_codec_pkg::ff_start;
          end else begin
            din_ready <= 1'b1;
          end
        end
        i2c_codec_pkg::ff_start: begin
          if (op_done) begin
            state <= i2c_codec_pkg::ff_dev_addr;
          end
        end
        i2c_codec_pkg::ff_dev_addr: begin
          if (op_done) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == dev_last) begin
              bit_cnt <= '0;
              state   <= i2c_codec_pkg::ff_rd_wr;
            end
          end
        end
        i2c_codec_pkg::ff_rd_wr: begin
          if (op_done) begin
            state <= i2c_codec_pkg::ff_ack;
          end
        end
        i2c_codec_pkg::ff_ack: begin
          if (op_done) begin
            ack_cnt <= ack_cnt + 1'b1;
            case (ack_cnt)
              ack_w'(0): state <= i2c_codec_pkg::ff_reg_addr;
              ack_w'(1): state <= i2c_codec_pkg::ff_data;
              default:   state <= i2c_codec_pkg::ff_stop;
            endcase
          end
        end
        i2c_codec_pkg::ff_reg_addr: begin
          if (op_done) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == reg_last) begin
              bit_cnt <= '0;
              state   <= i2c_codec_pkg::ff_data;
            end
          end
        end
        i2c_codec_pkg::ff_data: begin
          // data bit 8 closes the second byte, bit 0 the third
          if (op_done) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd0 || bit_cnt == data_last) begin
              state <= i2c_codec_pkg::ff_ack;
            end
          end
        end
        i2c_codec_pkg::ff_stop: begin
          if (op_done) begin
            dout_valid <= 1'b1;
            state      <= i2c_codec_pkg::ff_output;
          end
        end
        i2c_codec_pkg::ff_output: begin
          if (dout_ready) begin
            dout_valid <= 1'b0;
            state      <= i2c_codec_pkg::ff_idle;
          end
        end
        default: state <= i2c_codec_pkg::ff_idle;
      endcase
    end
  end

  // request fields and response payload
  always_ff @(posedge clk) begin
    if (accept) begin
      dev_q              <= din_device_address;
      rd_wr_q            <= din_rd_wr;
      reg_q              <= din_register_address;
      data_q             <= din_register_data;
      dout_register_data <= '0;
    end
    if (op_done) begin
      case (state)
        i2c_codec_pkg::ff_dev_addr: dev_q <= dev_q << 1;
        i2c_codec_pkg::ff_reg_addr: reg_q <= reg_q << 1;
        // slave pulls SDA low to acknowledge
        i2c_codec_pkg::ff_ack: dout_acks_received[ack_cnt] <= ~rx_bit;
        i2c_codec_pkg::ff_data: begin
          if (rd_wr_q) begin
            dout_register_data <= {dout_register_data[`CODEC_REG_DATA_W-2:0], rx_bit};
          end else begin
            data_q <= data_q << 1;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/i2c_bit_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "i2c_codec_defs.svh"

module i2c_bit_engine #(
  parameter int clk_div = `CODEC_CLK_DIV
) (
  input  logic                   clk,
  input  logic                   rst,
  input  i2c_codec_pkg::bus_op_e op,
  input  logic                   op_valid,
  input  logic                   tx_bit,
  input  logic                   sda_in,
  output logic                   op_done,
  output logic                   rx_bit,
  output logic                   scl,
  output logic                   sda_oe,
  output logic                   sda_out
);

  localparam int cnt_w = $clog2(clk_div);

  localparam logic [cnt_w-1:0] full_end = cnt_w'(clk_div - 1);
  localparam logic [cnt_w-1:0] half_end = cnt_w'(clk_div / 2 - 1);

  i2c_codec_pkg::bus_op_e op_q;

  logic             busy;
  logic             tx_q;
  logic [1:0]       phase;
  logic [1:0]       last_phase;
  logic [cnt_w-1:0] cnt;
  logic [cnt_w-1:0] phase_end;

  // phase count and length per condition
  always_comb begin
    last_phase = 2'd1;
    phase_end  = full_end;
    case (op_q)
      i2c_codec_pkg::op_start: last_phase = 2'd1;
      i2c_codec_pkg::op_stop:  last_phase = 2'd2;
      i2c_codec_pkg::op_write: begin
        last_phase = 2'd2;
        phase_end  = (phase == 2'd2) ? full_end : half_end;
      end
      default: begin
        last_phase = 2'd3;
        phase_end  = half_end;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      op_q    <= i2c_codec_pkg::op_start;
      busy    <= 1'b0;
      op_done <= 1'b0;
      phase   <= '0;
      cnt     <= '0;
      scl     <= 1'b1;
      sda_oe  <= 1'b1;
      sda_out <= 1'b1;
    end else begin
      op_done <= 1'b0;
      if (!busy) begin
        if (op_valid) begin
          busy  <= 1'b1;
          op_q  <= op;
          phase <= '0;
          cnt   <= '0;
          case (op)
            i2c_codec_pkg::op_start: begin
              scl     <= 1'b1;
              sda_oe  <= 1'b1;
              sda_out <= 1'b1;
            end
            i2c_codec_pkg::op_stop: begin
              scl     <= 1'b0;
              sda_oe  <= 1'b1;
              sda_out <= 1'b0;
            end
            default: scl <= 1'b0;
          endcase
        end
      end else if (cnt == phase_end) begin
        cnt <= '0;
        if (phase == last_phase) begin
          busy    <= 1'b0;
          op_done <= 1'b1;
          // stop leaves both lines high
          if (op_q != i2c_codec_pkg::op_stop) begin
            scl <= 1'b0;
          end
        end else begin
          phase <= phase + 2'd1;
          case (op_q)
            i2c_codec_pkg::op_start: sda_out <= 1'b0;
            i2c_codec_pkg::op_stop: begin
              if (phase == 2'd0) begin
                scl <= 1'b1;
              end else begin
                sda_out <= 1'b1;
              end
            end
            i2c_codec_pkg::op_write: begin
              if (phase == 2'd0) begin
                sda_oe  <= 1'b1;
                sda_out <= tx_q;
              end else begin
                scl <= 1'b1;
              end
            end
            default: begin
              if (phase == 2'd0) begin
                sda_oe <= 1'b0;
              end else if (phase == 2'd1) begin
                scl <= 1'b1;
              end
            end
          endcase
        end
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // bit to send, and SDA sampled mid SCL-high
  always_ff @(posedge clk) begin
    if (!busy && op_valid) begin
      tx_q <= tx_bit;
    end
    if (busy && op_q == i2c_codec_pkg::op_read && phase == 2'd2 && cnt == phase_end) begin
      rx_bit <= sda_in;
    end
  end

endmodule

`default_nettype wire

// File: src/i2c_codec_pkg.sv
`default_nettype none

package i2c_codec_pkg;

  // single condition driven by the bit engine
  typedef enum logic [1:0] {
    op_start,
    op_stop,
    op_write,
    op_read
  } bus_op_e;

  // position within one codec register frame
  typedef enum logic [3:0] {
    ff_idle,
    ff_start,
    ff_dev_addr,
    ff_rd_wr,
    ff_ack,
    ff_reg_addr,
    ff_data,
    ff_stop,
    ff_output
  } frame_field_e;

endpackage

`default_nettype wire

// File: src/i2c_codec_defs.svh
`ifndef I2C_CODEC_DEFS_SVH
`define I2C_CODEC_DEFS_SVH

// codec request field widths
`define CODEC_DEV_ADDR_W 7
`define CODEC_REG_ADDR_W 7
`define CODEC_REG_DATA_W 9

// one ack per byte on the wire
`define CODEC_ACK_SLOTS 3

// clk cycles per SCL half-period
// must be even and at least 4
`define CODEC_CLK_DIV 10

`endif
